//--- src/memStage_config.svh
/*
   Cache geometry shared by the instruction and data caches.
   Byte addresses are 32 bits and the two low bits pick a byte in a word.
   Both caches are direct-mapped with the same line size.
*/
`ifndef MEMSTAGE_CONFIG_SVH
`define MEMSTAGE_CONFIG_SVH

// Data and address word width
`define MS_WORD_WIDTH 32

// Line index bits, 16 lines per cache
`define MS_INDEX_WIDTH 4

// Word-in-line bits, 4 words per line
`define MS_OFFSET_WIDTH 2

// Whatever is left above index, offset and byte select
`define MS_TAG_WIDTH (`MS_WORD_WIDTH - `MS_INDEX_WIDTH - `MS_OFFSET_WIDTH - 2)

`endif

//--- src/mipsIsaPkg.sv
/*
   MIPS load/store opcodes as seen in the stage-4 instruction.
   Only memory instructions are named; every other opcode is neither.
*/
package mipsIsaPkg;

   // Opcode field, bits 31:26 of the instruction
   typedef enum logic [5:0] {
      LB  = 6'b100000,
      LH  = 6'b100001,
      LW  = 6'b100011,
      LBU = 6'b100100,
      LHU = 6'b100101,
      SB  = 6'b101000,
      SH  = 6'b101001,
      SW  = 6'b101011
   } opcode_t;

   // Width of a store, selects the merge lane
   typedef enum logic [1:0] {
      sizeWord,
      sizeHalf,
      sizeByte
   } storeSize_t;

endpackage

//--- src/cachePkg.sv
/*
   Address split and controller states for both caches.
   Address layout is {tag, index, word offset, byte select}.
*/
`include "memStage_config.svh"

package cachePkg;

   typedef logic [`MS_WORD_WIDTH-1:0]   word_t;
   typedef logic [`MS_TAG_WIDTH-1:0]    tag_t;
   typedef logic [`MS_INDEX_WIDTH-1:0]  index_t;
   typedef logic [`MS_OFFSET_WIDTH-1:0] offset_t;

   // Instruction cache miss FSM
   typedef enum logic [1:0] {iIdle, iWaitMem, iRefill} iFsm_t;

   // Data cache FSM, write-back runs before refill
   typedef enum logic [2:0] {dIdle, dStoreHit, dWriteBack, dWaitMem, dRefill} dFsm_t;

   // ------------------------------
   // Address field helpers
   function automatic tag_t tagOf(word_t a);
      return a[`MS_WORD_WIDTH-1 -: `MS_TAG_WIDTH];
   endfunction

   function automatic index_t indexOf(word_t a);
      return a[`MS_OFFSET_WIDTH+2 +: `MS_INDEX_WIDTH];
   endfunction

   function automatic offset_t offsetOf(word_t a);
      return a[2 +: `MS_OFFSET_WIDTH];
   endfunction

   // Word-aligned byte address from its fields
   function automatic word_t wordAddr(tag_t t, index_t i, offset_t o);
      return {t, i, o, 2'b00};
   endfunction

endpackage

//--- src/memBusIf.sv
/*
   One cache's request toward the bus arbiter.
   Read and write are levels; valid is the one-cycle first-word pulse.
*/
interface memBusIf;

   logic            read;
   logic            write;
   cachePkg::word_t addr;
   cachePkg::word_t wdata;
   cachePkg::word_t rdata;
   logic            valid;

   // Cache side
   modport client (output read, output write, output addr, output wdata,
                   input rdata, input valid);

   // Arbiter side
   modport arbiter (input read, input write, input addr, input wdata,
                    output rdata, output valid);

endinterface

//--- src/cacheArray.sv
/*
   Direct-mapped tag, valid and data store with asynchronous reads.
   Writes land on the clock edge; only the valid bits are reset.
*/
`include "memStage_config.svh"

module cacheArray (
   input  logic              CLK,
   input  logic              MRST,
   input  cachePkg::index_t  index,
   input  cachePkg::offset_t wordSel,
   input  cachePkg::tag_t    lookupTag,
   input  cachePkg::tag_t    fillTag,
   input  logic              dataWe,
   input  cachePkg::word_t   dataIn,
   input  logic              tagWe,
   output cachePkg::word_t   dataOut,
   output cachePkg::tag_t    tagOut,
   output logic              hit
);

   localparam int NUM_LINES = 1 << `MS_INDEX_WIDTH;
   localparam int NUM_WORDS = NUM_LINES << `MS_OFFSET_WIDTH;

   cachePkg::tag_t       tagMem [NUM_LINES];
   cachePkg::word_t      dataMem [NUM_WORDS];
   logic [NUM_LINES-1:0] validBits;

   // Storage writes
   always_ff @(posedge CLK) begin
      if (tagWe) begin
         tagMem[index] <= fillTag;
      end
      if (dataWe) begin
         dataMem[{index, wordSel}] <= dataIn;
      end
   end

   // A line turns valid together with its tag
   always_ff @(posedge CLK) begin
      if (MRST) begin
         validBits <= '0;
      end else if (tagWe) begin
         validBits[index] <= 1'b1;
      end
   end

   assign tagOut  = tagMem[index];
   assign dataOut = dataMem[{index, wordSel}];
   assign hit     = validBits[index] && (tagOut == lookupTag);

endmodule

//--- src/loadStoreDecode.sv
/*
   Load/store decode of the stage-4 instruction and sub-word store merge.
   Lanes are big-endian: byte 0 sits in bits 31:24.
*/
module loadStoreDecode (
   input  cachePkg::word_t instr,
   input  logic [1:0]      byteAddr,
   input  cachePkg::word_t oldWord,
   input  cachePkg::word_t storeData,
   output logic            isLoad,
   output logic            isStore,
   output cachePkg::word_t merged
);

   mipsIsaPkg::opcode_t    opcode;
   mipsIsaPkg::storeSize_t size;
   logic [4:0]             shiftAmt;
   cachePkg::word_t        laneMask;

   assign opcode = mipsIsaPkg::opcode_t'(instr[31:26]);

   // Opcode decode
   always_comb begin
      isLoad  = 1'b0;
      isStore = 1'b0;
      size    = mipsIsaPkg::sizeWord;
      case (opcode)
         mipsIsaPkg::LW, mipsIsaPkg::LH, mipsIsaPkg::LHU,
         mipsIsaPkg::LB, mipsIsaPkg::LBU: isLoad = 1'b1;
         mipsIsaPkg::SW: isStore = 1'b1;
         mipsIsaPkg::SH: begin
            isStore = 1'b1;
            size    = mipsIsaPkg::sizeHalf;
         end
         mipsIsaPkg::SB: begin
            isStore = 1'b1;
            size    = mipsIsaPkg::sizeByte;
         end
         default: isLoad = 1'b0;
      endcase
   end

   // Lane select, byte lane is 3 minus address and half lane 1 minus bit 1
   always_comb begin
      case (size)
         mipsIsaPkg::sizeByte: begin
            shiftAmt = {~byteAddr, 3'b000};
            laneMask = 32'h0000_00ff << shiftAmt;
         end
         mipsIsaPkg::sizeHalf: begin
            shiftAmt = {~byteAddr[1], 4'b0000};
            laneMask = 32'h0000_ffff << shiftAmt;
         end
         default: begin
            shiftAmt = 5'd0;
            laneMask = '1;
         end
      endcase
   end

   // Keep the untouched bytes of the old word
   assign merged = (oldWord & ~laneMask) | ((storeData << shiftAmt) & laneMask);

endmodule

//--- src/instCache.sv
/*
   Instruction cache with a four-word line refill on a miss.
   Iaddr must stay stable while iStall is high. Never writes the bus.
*/
module instCache (
   input  logic            CLK,
   input  logic            MRST,
   input  cachePkg::word_t Iaddr,
   input  cachePkg::word_t BusIn,
   memBusIf.client         bus,
   output cachePkg::word_t Iin,
   output logic            iStall
);

   cachePkg::iFsm_t   state;
   cachePkg::offset_t fillOffset;
   cachePkg::offset_t wordSel;
   cachePkg::word_t   hitWord;
   logic              hit;
   logic              dataWe;
   logic              tagWe;

   cacheArray array (
      .CLK       (CLK),
      .MRST      (MRST),
      .index     (cachePkg::indexOf(Iaddr)),
      .wordSel   (wordSel),
      .lookupTag (cachePkg::tagOf(Iaddr)),
      .fillTag   (cachePkg::tagOf(Iaddr)),
      .dataWe    (dataWe),
      .dataIn    (BusIn),
      .tagWe     (tagWe),
      .dataOut   (hitWord),
      .tagOut    (),
      .hit       (hit)
   );

   // ------------------------------
   // Array control
   // Fetch word when idle, fill counter otherwise
   assign wordSel = (state == cachePkg::iIdle) ? cachePkg::offsetOf(Iaddr) : fillOffset;

   // Word 0 arrives with Valid, the rest follow back to back
   assign dataWe = ((state == cachePkg::iWaitMem) && bus.valid) || (state == cachePkg::iRefill);
   // Tag goes in with the last word
   assign tagWe  = (state == cachePkg::iRefill) && (fillOffset == '1);

   // Requests always start at the line base
   assign bus.addr = cachePkg::wordAddr(cachePkg::tagOf(Iaddr), cachePkg::indexOf(Iaddr), '0);

   assign iStall = !hit || (state != cachePkg::iIdle);
   assign Iin    = iStall ? '0 : hitWord;

   // ------------------------------
   // Miss FSM
   always_ff @(posedge CLK) begin
      if (MRST) begin
         state      <= cachePkg::iIdle;
         fillOffset <= '0;
         bus.read   <= 1'b0;
      end else begin
         case (state)
            cachePkg::iIdle: begin
               if (!hit) begin
                  state    <= cachePkg::iWaitMem;
                  bus.read <= 1'b1;
               end
            end
            cachePkg::iWaitMem: begin
               if (bus.valid) begin
                  state      <= cachePkg::iRefill;
                  fillOffset <= fillOffset + 1'b1;
               end
            end
            cachePkg::iRefill: begin
               // Counter wraps back to 0 after the last word
               fillOffset <= fillOffset + 1'b1;
               if (fillOffset == '1) begin
                  state    <= cachePkg::iIdle;
                  bus.read <= 1'b0;
               end
            end
            default: state <= cachePkg::iIdle;
         endcase
      end
   end

endmodule

//--- src/dataCache.sv
/*
   Write-back data cache for loads and stores of the stage-4 instruction.
   I3, MAR and SMDR must hold while dStall is high.
   A miss waits for grantFree so the two caches never share a transfer.
*/
`include "memStage_config.svh"

module dataCache (
   input  logic            CLK,
   input  logic            MRST,
   input  cachePkg::word_t I3,
   input  cachePkg::word_t MAR,
   input  cachePkg::word_t SMDR,
   input  cachePkg::word_t BusIn,
   input  logic            grantFree,
   memBusIf.client         bus,
   output cachePkg::word_t cacheOut,
   output logic            dStall
);

   localparam int NUM_LINES = 1 << `MS_INDEX_WIDTH;

   cachePkg::dFsm_t      state;
   cachePkg::offset_t    lineOffset;
   cachePkg::index_t     storeIndex;
   cachePkg::offset_t    storeOffset;
   cachePkg::word_t      storeWord;
   logic [NUM_LINES-1:0] dirty;
   cachePkg::index_t     missIndex;
   cachePkg::index_t     arrayIndex;
   cachePkg::offset_t    wordSel;
   cachePkg::word_t      hitWord;
   cachePkg::word_t      dataIn;
   cachePkg::word_t      merged;
   cachePkg::tag_t       lineTag;
   logic                 hit;
   logic                 dataWe;
   logic                 tagWe;
   logic                 isLoad;
   logic                 isStore;
   logic                 storeHit;

   cacheArray array (
      .CLK       (CLK),
      .MRST      (MRST),
      .index     (arrayIndex),
      .wordSel   (wordSel),
      .lookupTag (cachePkg::tagOf(MAR)),
      .fillTag   (cachePkg::tagOf(MAR)),
      .dataWe    (dataWe),
      .dataIn    (dataIn),
      .tagWe     (tagWe),
      .dataOut   (hitWord),
      .tagOut    (lineTag),
      .hit       (hit)
   );

   loadStoreDecode decode (
      .instr     (I3),
      .byteAddr  (MAR[1:0]),
      .oldWord   (hitWord),
      .storeData (SMDR),
      .isLoad    (isLoad),
      .isStore   (isStore),
      .merged    (merged)
   );

   // ------------------------------
   // Array control
   assign missIndex = cachePkg::indexOf(MAR);
   assign storeHit  = (state == cachePkg::dIdle) && isStore && hit;

   // Store hit writes back into the address it was taken at
   assign arrayIndex = (state == cachePkg::dStoreHit) ? storeIndex : missIndex;

   always_comb begin
      case (state)
         cachePkg::dIdle:     wordSel = cachePkg::offsetOf(MAR);
         cachePkg::dStoreHit: wordSel = storeOffset;
         default:             wordSel = lineOffset;
      endcase
   end

   assign dataWe = (state == cachePkg::dStoreHit) || (state == cachePkg::dRefill) ||
                   ((state == cachePkg::dWaitMem) && bus.valid);
   assign dataIn = (state == cachePkg::dStoreHit) ? storeWord : BusIn;
   assign tagWe  = (state == cachePkg::dRefill) && (lineOffset == '1);

   // Old line address during write-back, new line base otherwise
   assign bus.addr  = (state == cachePkg::dWriteBack) ?
                      cachePkg::wordAddr(lineTag, missIndex, lineOffset) :
                      cachePkg::wordAddr(cachePkg::tagOf(MAR), missIndex, '0);
   assign bus.wdata = hitWord;

   assign dStall   = (isLoad || isStore) && (!hit || (state != cachePkg::dIdle));
   assign cacheOut = isLoad ? hitWord : '0;

   // Merged word and its place, written one cycle later
   always_ff @(posedge CLK) begin
      if (storeHit) begin
         storeIndex  <= missIndex;
         storeOffset <= cachePkg::offsetOf(MAR);
         storeWord   <= merged;
      end
   end

   // ------------------------------
   // Controller FSM
   always_ff @(posedge CLK) begin
      if (MRST) begin
         state      <= cachePkg::dIdle;
         lineOffset <= '0;
         dirty      <= '0;
         bus.read   <= 1'b0;
         bus.write  <= 1'b0;
      end else begin
         case (state)
            cachePkg::dIdle: begin
               if ((isLoad || isStore) && !hit && grantFree) begin
                  // Dirty victim goes out first, the refill follows from idle
                  if (dirty[missIndex]) begin
                     state     <= cachePkg::dWriteBack;
                     bus.write <= 1'b1;
                  end else begin
                     state    <= cachePkg::dWaitMem;
                     bus.read <= 1'b1;
                  end
               end else if (storeHit) begin
                  state <= cachePkg::dStoreHit;
               end
            end
            cachePkg::dStoreHit: begin
               dirty[storeIndex] <= 1'b1;
               state             <= cachePkg::dIdle;
            end
            cachePkg::dWriteBack: begin
               // One word per cycle, Write held for four cycles
               lineOffset <= lineOffset + 1'b1;
               if (lineOffset == '1) begin
                  state            <= cachePkg::dIdle;
                  bus.write        <= 1'b0;
                  dirty[missIndex] <= 1'b0;
               end
            end
            cachePkg::dWaitMem: begin
               if (bus.valid) begin
                  state      <= cachePkg::dRefill;
                  lineOffset <= lineOffset + 1'b1;
               end
            end
            cachePkg::dRefill: begin
               lineOffset <= lineOffset + 1'b1;
               if (lineOffset == '1) begin
                  state    <= cachePkg::dIdle;
                  bus.read <= 1'b0;
               end
            end
            default: state <= cachePkg::dIdle;
         endcase
      end
   end

endmodule

//--- src/busArbiter.sv
/*
   Shares the memory bus between the two caches.
   The data cache wins only while the instruction cache is not reading.
*/
module busArbiter (
   input  logic            CLK,
   input  logic            MRST,
   memBusIf.arbiter        iBus,
   memBusIf.arbiter        dBus,
   input  logic            Valid,
   output logic            Read,
   output logic            Write,
   output cachePkg::word_t Addr,
   output cachePkg::word_t BusOut
);

   logic owner;     // High while the data cache holds the bus
   logic dRequest;
   logic dataSel;

   assign dRequest = dBus.read | dBus.write;

   // Grant takes effect in the cycle the request rises
   assign dataSel = owner | (dRequest & ~iBus.read);

   // Ownership drops back once both data levels are low
   always_ff @(posedge CLK) begin
      if (MRST) begin
         owner <= 1'b0;
      end else begin
         owner <= dataSel & dRequest;
      end
   end

   // Request routing
   assign Read   = dataSel ? dBus.read : iBus.read;
   assign Write  = dataSel & dBus.write;
   assign Addr   = dataSel ? dBus.addr : iBus.addr;
   assign BusOut = dBus.wdata;

   // Valid reaches the owner only
   assign iBus.valid = Valid & ~dataSel;
   assign dBus.valid = Valid & dataSel;

endmodule

//--- src/memStage.sv
/*
   Memory stage top: instruction cache, data cache and bus arbiter.
   The pipeline holds I3, MAR, SMDR and Iaddr while pipeInhibit is high.
*/
module memStage (
   input  logic            CLK,
   input  logic            MRST,
   input  cachePkg::word_t I3,
   input  cachePkg::word_t MAR,
   input  cachePkg::word_t SMDR,
   input  cachePkg::word_t Iaddr,
   input  logic            Valid,
   input  cachePkg::word_t BusIn,
   output logic            Read,
   output logic            Write,
   output cachePkg::word_t Addr,
   output cachePkg::word_t BusOut,
   output cachePkg::word_t cacheOut,
   output cachePkg::word_t Iin,
   output logic            pipeInhibit,
   output logic            pcInhibit
);

   logic iStall;
   logic dStall;

   memBusIf iBus ();
   memBusIf dBus ();

   // Read data reaches both caches unchanged
   assign iBus.rdata = BusIn;
   assign dBus.rdata = BusIn;

   instCache iCache (
      .CLK    (CLK),
      .MRST   (MRST),
      .Iaddr  (Iaddr),
      .BusIn  (BusIn),
      .bus    (iBus),
      .Iin    (Iin),
      .iStall (iStall)
   );

   // Data misses wait until the fetch side is quiet
   dataCache dCache (
      .CLK       (CLK),
      .MRST      (MRST),
      .I3        (I3),
      .MAR       (MAR),
      .SMDR      (SMDR),
      .BusIn     (BusIn),
      .grantFree (~iStall),
      .bus       (dBus),
      .cacheOut  (cacheOut),
      .dStall    (dStall)
   );

   busArbiter arbiter (
      .CLK    (CLK),
      .MRST   (MRST),
      .iBus   (iBus),
      .dBus   (dBus),
      .Valid  (Valid),
      .Read   (Read),
      .Write  (Write),
      .Addr   (Addr),
      .BusOut (BusOut)
   );

   // ------------------------------
   // Pipeline stall
   assign pipeInhibit = iStall | dStall;

   // PC stall lags one cycle
   always_ff @(posedge CLK) begin
      if (MRST) begin
         pcInhibit <= 1'b0;
      end else begin
         pcInhibit <= pipeInhibit;
      end
   end

endmodule

//--- bench/memoryModel.sv
/*
   Behavioral main memory of 4 KB on the split bus, word addressed by Addr[11:2].
   A read answers 1 to 4 cycles after Read is seen, then streams four words.
   Every cycle with Write high stores one word. The array is read by the bench.
*/
module memoryModel (
   input  logic            CLK,
   input  logic            Read,
   input  logic            Write,
   input  cachePkg::word_t Addr,
   input  cachePkg::word_t BusOut,
   output logic            Valid,
   output cachePkg::word_t BusIn
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int MEM_WORDS = 1024;

   cachePkg::word_t mem [MEM_WORDS];
   int              seed = 96;

   // Fill pattern built from the whole byte address
   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = (32'(i) << 2) ^ (32'(i) << 18) ^ 32'hc35a_0000;
      end
   end

   // ------------------------------
   // Bus responder, works on falling edges where the requests are stable
   initial begin
      int              delay;
      cachePkg::word_t base;
      Valid = 1'b0;
      BusIn = '0;
      forever begin
         @(negedge CLK);
         if (Write) begin
            mem[Addr[11:2]] = BusOut;
         end else if (Read) begin
            base  = Addr;
            delay = 1 + ($unsigned($random(seed)) % 4);
            repeat (delay - 1) @(negedge CLK);
            // Word 0 with the Valid pulse, words 1 to 3 back to back
            for (int w = 0; w < 4; w++) begin
               Valid = (w == 0);
               BusIn = mem[{base[11:4], 2'(w)}];
               @(negedge CLK);
            end
            Valid = 1'b0;
         end
      end
   end

endmodule

//--- bench/memStageTb.sv
/*
   Testbench for the memory stage with a behavioral memory on the bus.
   Fetches stay in 0x800-0x9FF and data in 0x000-0x3FF, so no word sits in both
   caches. Memory covers 4 KB only.
*/
module memStageTb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int MEM_WORDS  = 1024;
   localparam int STEP_LIMIT = 200;

   // MIPS opcode field values
   localparam logic [5:0] OP_LB  = 6'h20;
   localparam logic [5:0] OP_LH  = 6'h21;
   localparam logic [5:0] OP_LW  = 6'h23;
   localparam logic [5:0] OP_LBU = 6'h24;
   localparam logic [5:0] OP_LHU = 6'h25;
   localparam logic [5:0] OP_SB  = 6'h28;
   localparam logic [5:0] OP_SH  = 6'h29;
   localparam logic [5:0] OP_SW  = 6'h2b;

   logic            CLK;
   logic            MRST;
   cachePkg::word_t I3;
   cachePkg::word_t MAR;
   cachePkg::word_t SMDR;
   cachePkg::word_t Iaddr;
   logic            Valid;
   cachePkg::word_t BusIn;
   logic            Read;
   logic            Write;
   cachePkg::word_t Addr;
   cachePkg::word_t BusOut;
   cachePkg::word_t cacheOut;
   cachePkg::word_t Iin;
   logic            pipeInhibit;
   logic            pcInhibit;

   // Expected memory image kept in step with accepted stores
   cachePkg::word_t shadow [MEM_WORDS];

   // Per-edge monitor state
   logic            prevPipe   = 1'b0;
   logic            prevWrite  = 1'b0;
   logic            firstCycle = 1'b1;
   cachePkg::word_t prevAddr   = '0;
   cachePkg::word_t burstBase  = '0;
   int              burstLen   = 0;
   int              writeBeats = 0;
   int              stepCount  = 0;
   int              stimSeed   = 96;

   initial begin
      CLK = 1'b0;
      forever #4 CLK = ~CLK;
   end

   memStage DUT (
      .CLK         (CLK),
      .MRST        (MRST),
      .I3          (I3),
      .MAR         (MAR),
      .SMDR        (SMDR),
      .Iaddr       (Iaddr),
      .Valid       (Valid),
      .BusIn       (BusIn),
      .Read        (Read),
      .Write       (Write),
      .Addr        (Addr),
      .BusOut      (BusOut),
      .cacheOut    (cacheOut),
      .Iin         (Iin),
      .pipeInhibit (pipeInhibit),
      .pcInhibit   (pcInhibit)
   );

   memoryModel memory (
      .CLK    (CLK),
      .Read   (Read),
      .Write  (Write),
      .Addr   (Addr),
      .BusOut (BusOut),
      .Valid  (Valid),
      .BusIn  (BusIn)
   );

   // ------------------------------
   // Failure reporting and value checks
   task automatic reportFailure(input string what);
      $display("%s", what);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic checkValue(input string name, input cachePkg::word_t got,
                             input cachePkg::word_t expected);
      assert (got === expected)
         else reportFailure($sformatf("Fail %s: got %h, expected %h", name, got, expected));
   endtask

   // ------------------------------
   // Instruction helpers
   function automatic cachePkg::word_t memOp(input logic [5:0] op);
      // Base register 1, data register 2, offset unused
      return {op, 5'd1, 5'd2, 16'h0000};
   endfunction

   function automatic logic isLoadOp(input cachePkg::word_t instr);
      logic result;
      case (instr[31:26])
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: result = 1'b1;
         default: result = 1'b0;
      endcase
      return result;
   endfunction

   function automatic logic isStoreOp(input cachePkg::word_t instr);
      logic result;
      case (instr[31:26])
         OP_SB, OP_SH, OP_SW: result = 1'b1;
         default: result = 1'b0;
      endcase
      return result;
   endfunction

   // Big-endian lanes with byte 0 in bits 31:24
   function automatic cachePkg::word_t applyStore(input cachePkg::word_t oldWord,
                                                  input cachePkg::word_t instr,
                                                  input cachePkg::word_t data,
                                                  input logic [1:0] byteSel);
      cachePkg::word_t result;
      result = oldWord;
      case (instr[31:26])
         OP_SW: result = data;
         OP_SH: result[16 * (1 - byteSel[1]) +: 16] = data[15:0];
         OP_SB: result[8 * (3 - byteSel) +: 8] = data[7:0];
         default: result = oldWord;
      endcase
      return result;
   endfunction

   // ------------------------------
   // Edge monitor sampling settled values at the rising edge
   always @(posedge CLK) begin
      if (MRST) begin
         prevPipe   = 1'b0;
         prevWrite  = 1'b0;
         firstCycle = 1'b1;
      end else begin
         // Bus and PC stall still at reset values
         if (firstCycle) begin
            checkValue("Read", Read, '0);
            checkValue("Write", Write, '0);
            checkValue("pcInhibit", pcInhibit, '0);
         end
         firstCycle = 1'b0;
         checkValue("pcInhibit", pcInhibit, prevPipe);
         assert (!(Read && Write))
            else reportFailure("Read and Write were high in the same cycle");
         if (Read) begin
            checkValue("Addr[3:0] on read", Addr & 32'hf, '0);
         end
         // Write-back burst of one word per cycle
         if (Write) begin
            if (prevWrite) begin
               checkValue("Addr on write-back", Addr, prevAddr + 32'd4);
            end else begin
               checkValue("Addr[3:0] on write-back", Addr & 32'hf, '0);
               burstBase = Addr;
               burstLen  = 0;
            end
            burstLen++;
            writeBeats++;
         end else if (prevWrite) begin
            assert (burstLen == 4)
               else reportFailure("A write-back burst was not four words long");
         end
         prevWrite = Write;
         prevAddr  = Addr;
         prevPipe  = pipeInhibit;
         if (!isLoadOp(I3)) begin
            checkValue("cacheOut", cacheOut, '0);
         end
         // Fetch and load see the shadow image in an accepted cycle
         if (!pipeInhibit) begin
            checkValue("Iin", Iin, shadow[Iaddr[11:2]]);
            if (isLoadOp(I3)) begin
               checkValue("cacheOut", cacheOut, shadow[MAR[11:2]]);
            end
            if (isStoreOp(I3)) begin
               shadow[MAR[11:2]] = applyStore(shadow[MAR[11:2]], I3, SMDR, MAR[1:0]);
            end
         end
      end
   end

   // ------------------------------
   // One pipeline step held until a rising edge with pipeInhibit low
   task automatic issue(input cachePkg::word_t instr, input cachePkg::word_t addr,
                        input cachePkg::word_t data);
      int waited;
      waited = 0;
      @(negedge CLK);
      // Fetch stride wraps so 0x800 and 0x900 lines fight for the same slots
      Iaddr = 32'h800 + ((stepCount * 20) % 512);
      I3    = instr;
      MAR   = addr;
      SMDR  = data;
      stepCount++;
      @(posedge CLK);
      while (pipeInhibit !== 1'b0 && waited < STEP_LIMIT) begin
         @(posedge CLK);
         waited++;
      end
      assert (pipeInhibit === 1'b0)
         else reportFailure("Timeout while waiting for pipeInhibit to drop");
   endtask

   // ------------------------------
   // Stimulus script
   initial begin
      int              pick;
      int              beatsBefore;
      logic [5:0]      op;
      cachePkg::word_t addr;
      cachePkg::word_t data;
      I3    = '0;
      MAR   = '0;
      SMDR  = '0;
      Iaddr = 32'h800;
      MRST  = 1'b1;
      repeat (8) @(posedge CLK);
      @(negedge CLK);
      MRST = 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         shadow[i] = memory.mem[i];
      end

      // Fetch only steps followed by load misses and hits
      repeat (3) issue('0, '0, '0);
      issue(memOp(OP_LW), 32'h000, '0);
      issue(memOp(OP_LW), 32'h004, '0);
      issue(memOp(OP_LH), 32'h00e, '0);

      // Byte store to each lane with junk in the upper data bytes
      for (int lane = 0; lane < 4; lane++) begin
         issue(memOp(OP_SB), 32'h080 + lane, 32'hdead_be00 | (32'(lane + 1) * 32'h11));
      end
      issue(memOp(OP_LW), 32'h080, '0);
      checkValue("cacheOut after byte stores", cacheOut, 32'h1122_3344);
      // Half-word stores to both halves
      issue(memOp(OP_SH), 32'h090, 32'hffff_1234);
      issue(memOp(OP_SH), 32'h092, 32'h0000_5678);
      issue(memOp(OP_LW), 32'h090, '0);
      checkValue("cacheOut after half stores", cacheOut, 32'h1234_5678);
      issue(memOp(OP_SW), 32'h0a0, 32'hcafe_f00d);
      issue(memOp(OP_LBU), 32'h0a3, '0);
      checkValue("cacheOut after word store", cacheOut, 32'hcafe_f00d);

      // Dirty line at 0x040 evicted by a load to 0x140
      issue(memOp(OP_SW), 32'h040, 32'h0bad_cafe);
      beatsBefore = writeBeats;
      issue(memOp(OP_LW), 32'h140, '0);
      @(negedge CLK);
      checkValue("write-back beats", writeBeats - beatsBefore, 32'd4);
      checkValue("write-back base", burstBase, 32'h040);
      checkValue("memory word 0x040", memory.mem[16], 32'h0bad_cafe);
      for (int w = 0; w < 4; w++) begin
         checkValue("memory line 0x040", memory.mem[16 + w], shadow[16 + w]);
      end
      // Victim is clean now so the reload only reads
      issue(memOp(OP_LW), 32'h040, '0);
      checkValue("cacheOut on reload", cacheOut, 32'h0bad_cafe);
      checkValue("write-back beats", writeBeats - beatsBefore, 32'd4);
      // Byte-merged line out and back
      issue(memOp(OP_LW), 32'h280, '0);
      issue(memOp(OP_LW), 32'h080, '0);

      // Mixed traffic over four tags per index
      for (int n = 0; n < 40; n++) begin
         pick = $unsigned($random(stimSeed)) % 6;
         addr = {22'h0, 10'($random(stimSeed))};
         data = $random(stimSeed);
         case (pick)
            0, 1:    op = OP_LW;
            2:       op = OP_SW;
            3:       op = OP_SH;
            4:       op = OP_SB;
            default: op = OP_LBU;
         endcase
         issue(memOp(op), addr, data);
      end
      issue('0, '0, '0);

      $display("Regression passed");
      $finish;
   end

endmodule

//--- sim.f
+incdir+src
src/mipsIsaPkg.sv
src/cachePkg.sv
src/memBusIf.sv
src/cacheArray.sv
src/loadStoreDecode.sv
src/instCache.sv
src/dataCache.sv
src/busArbiter.sv
src/memStage.sv
bench/memoryModel.sv
bench/memStageTb.sv
